// ==== hw/control_word_sync.sv ====
// Control word stability filter on the ASIC clock and the
// accepted-word register on the fabric clock.
`default_nettype none

module control_word_sync
  import efpga_ctrl_pkg::*;
(
  input  logic              asic_clk_i,
  input  logic              efpga_clk_i,
  input  logic              rst_n,
  input  logic [CTRL_W-1:0] ctrl_word_i,
  output logic [CTRL_W-1:0] ctrl_word_o
);

  logic [CTRL_W-1:0] word_dly_q [STABLE_SAMPLES-1];  // [0] is the newest copy
  logic              all_equal;
  logic              word_valid_q;

  // input must match every delayed copy
  always_comb begin
    all_equal = 1'b1;
    for (int k = 0; k < STABLE_SAMPLES - 1; k++) begin
      if (word_dly_q[k] != ctrl_word_i) begin
        all_equal = 1'b0;
      end
    end
  end

  always_ff @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < STABLE_SAMPLES - 1; k++) begin
        word_dly_q[k] <= '0;
      end
      word_valid_q <= 1'b0;
    end else begin
      word_dly_q[0] <= ctrl_word_i;
      for (int k = 1; k < STABLE_SAMPLES - 1; k++) begin
        word_dly_q[k] <= word_dly_q[k-1];
      end
      word_valid_q <= all_equal;  // one asic cycle after the match
    end
  end

  // The valid flag only rises once the bus has been quiet for several
  // asic samples, so the delayed copy is steady when the fabric side
  // picks it up.
  always_ff @(posedge efpga_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_word_o <= '0;
    end else if (word_valid_q) begin
      ctrl_word_o <= word_dly_q[0];
    end
  end

endmodule

`default_nettype wire

// ==== hw/efpga_cdc_bridge.sv ====
// Top level of the ASIC/fabric crossing: control word stabilizer,
// event gate, per-line event channels and the event collector.
`default_nettype none

module efpga_cdc_bridge
  import efpga_ctrl_pkg::*;
(
  input  logic                asic_clk_i,
  input  logic                efpga_clk_i,
  input  logic                rst_n,
  input  logic [CTRL_W-1:0]   ctrl_word_i,
  output logic [CTRL_W-1:0]   ctrl_word_o,
  input  logic                event_en_i,
  input  logic [N_EVENTS-1:0] fab_event_i,
  input  logic [N_EVENTS-1:0] event_clr_i,
  output logic [N_EVENTS-1:0] efpga_event_o,
  output logic [N_EVENTS-1:0] event_pending_o
);

  logic [N_EVENTS-1:0] req_pulse;    // fabric domain
  logic [N_EVENTS-1:0] event_pulse;  // asic domain

  control_word_sync u_ctrl_sync (
    .asic_clk_i  (asic_clk_i),
    .efpga_clk_i (efpga_clk_i),
    .rst_n       (rst_n),
    .ctrl_word_i (ctrl_word_i),
    .ctrl_word_o (ctrl_word_o)
  );

  event_gate u_event_gate (
    .efpga_clk_i (efpga_clk_i),
    .rst_n       (rst_n),
    .event_en_i  (event_en_i),
    .fab_event_i (fab_event_i),
    .req_pulse_o (req_pulse)
  );

  for (genvar g = 0; g < N_EVENTS; g++) begin : g_event_chan
    event_channel u_chan (
      .efpga_clk_i   (efpga_clk_i),
      .asic_clk_i    (asic_clk_i),
      .rst_n         (rst_n),
      .req_pulse_i   (req_pulse[g]),
      .event_pulse_o (event_pulse[g])
    );
  end

  event_collect u_event_collect (
    .asic_clk_i      (asic_clk_i),
    .rst_n           (rst_n),
    .event_pulse_i   (event_pulse),
    .event_clr_i     (event_clr_i),
    .efpga_event_o   (efpga_event_o),
    .event_pending_o (event_pending_o)
  );

endmodule

`default_nettype wire

// ==== hw/efpga_cdc_pkg.sv ====
// Clock crossing constants and the event channel state type.
`default_nettype none

package efpga_cdc_pkg;

  localparam int unsigned SYNC_STAGES = 2;  // flops per synchronizer

  typedef enum logic [1:0] {
    IDLE    = 2'b00,  // no request
    REQ     = 2'b01,  // req high, waiting for ack to rise
    RELEASE = 2'b10   // req low, waiting for ack to fall
  } chan_state_e;

endpackage

`default_nettype wire

// ==== hw/efpga_ctrl_pkg.sv ====
// Sizes of the ASIC-side control word and the fabric event vector.
// Also the sample count for the control word stability filter.
`default_nettype none

package efpga_ctrl_pkg;

  // control word coming from the ASIC side
  localparam int unsigned CTRL_W = 32;

  // fabric event lines
  localparam int unsigned N_EVENTS = 16;

  // equal asic samples before a control word is accepted
  localparam int unsigned STABLE_SAMPLES = 3;

endpackage

`default_nettype wire

// ==== hw/event_channel.sv ====
// One event crossing: fabric request FSM with a queued-request bit,
// ASIC-side synchronizer with edge pulse and acknowledge return.
`default_nettype none

module event_channel
  import efpga_cdc_pkg::*;
(
  input  logic efpga_clk_i,
  input  logic asic_clk_i,
  input  logic rst_n,
  input  logic req_pulse_i,
  output logic event_pulse_o
);

  chan_state_e            state_q;
  logic                   req_q;
  logic                   pend_q;
  logic [SYNC_STAGES-1:0] ack_sync_q;
  logic                   ack_s;
  logic [SYNC_STAGES-1:0] req_sync_q;
  logic                   req_s;
  logic                   req_s_d_q;

  assign ack_s = ack_sync_q[SYNC_STAGES-1];
  assign req_s = req_sync_q[SYNC_STAGES-1];

  // fabric half
  always_ff @(posedge efpga_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      req_q   <= 1'b0;
      pend_q  <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (req_pulse_i || pend_q) begin
            req_q   <= 1'b1;
            pend_q  <= pend_q & req_pulse_i;  // new pulse stays queued behind the old one
            state_q <= REQ;
          end
        end
        REQ: begin
          if (req_pulse_i) begin
            pend_q <= 1'b1;
          end
          if (ack_s) begin
            req_q   <= 1'b0;
            state_q <= RELEASE;
          end
        end
        RELEASE: begin
          if (req_pulse_i) begin
            pend_q <= 1'b1;
          end
          if (!ack_s) begin
            state_q <= IDLE;
          end
        end
        default: begin
          req_q   <= 1'b0;
          state_q <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge efpga_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      ack_sync_q <= '0;
    end else begin
      ack_sync_q <= {ack_sync_q[SYNC_STAGES-2:0], req_s};  // ack is the synced req
    end
  end

  // asic half
  always_ff @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      req_sync_q <= '0;
      req_s_d_q  <= 1'b0;
    end else begin
      req_sync_q <= {req_sync_q[SYNC_STAGES-2:0], req_q};
      req_s_d_q  <= req_s;
    end
  end

  assign event_pulse_o = req_s & ~req_s_d_q;  // one asic cycle per transfer

endmodule

`default_nettype wire

// ==== hw/event_collect.sv ====
// ASIC-side event outputs: registered pulses and sticky pending bits
// with a per-line clear strobe.
`default_nettype none

module event_collect
  import efpga_ctrl_pkg::*;
(
  input  logic                asic_clk_i,
  input  logic                rst_n,
  input  logic [N_EVENTS-1:0] event_pulse_i,
  input  logic [N_EVENTS-1:0] event_clr_i,
  output logic [N_EVENTS-1:0] efpga_event_o,
  output logic [N_EVENTS-1:0] event_pending_o
);

  logic [N_EVENTS-1:0] pending_nxt;

  // set beats clear when both land together
  assign pending_nxt = (event_pending_o & ~event_clr_i) | event_pulse_i;

  always_ff @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      efpga_event_o <= '0;
    end else begin
      efpga_event_o <= event_pulse_i;
    end
  end

  always_ff @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      event_pending_o <= '0;
    end else begin
      event_pending_o <= pending_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== hw/event_gate.sv ====
// Fabric-side event gating: enable synchronizer, masking of the event
// lines and rising-edge request pulses.
`default_nettype none

module event_gate
  import efpga_ctrl_pkg::*;
  import efpga_cdc_pkg::*;
(
  input  logic                efpga_clk_i,
  input  logic                rst_n,
  input  logic                event_en_i,
  input  logic [N_EVENTS-1:0] fab_event_i,
  output logic [N_EVENTS-1:0] req_pulse_o
);

  logic [SYNC_STAGES-1:0] en_sync_q;
  logic                   en_s;
  logic [N_EVENTS-1:0]    masked_q;
  logic [N_EVENTS-1:0]    masked_d_q;

  assign en_s = en_sync_q[SYNC_STAGES-1];

  always_ff @(posedge efpga_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      en_sync_q <= '0;
    end else begin
      en_sync_q <= {en_sync_q[SYNC_STAGES-2:0], event_en_i};  // enable comes from asic side
    end
  end

  always_ff @(posedge efpga_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      masked_q   <= '0;
      masked_d_q <= '0;
    end else begin
      masked_q   <= fab_event_i & {N_EVENTS{en_s}};
      masked_d_q <= masked_q;
    end
  end

  assign req_pulse_o = masked_q & ~masked_d_q;  // 0 -> 1 per line

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+verification
hw/efpga_ctrl_pkg.sv
hw/efpga_cdc_pkg.sv
hw/control_word_sync.sv
hw/event_gate.sv
hw/event_channel.sv
hw/event_collect.sv
hw/efpga_cdc_bridge.sv
verification/tb_efpga_cdc_bridge.sv

// ==== verification/tb_ref_model.svh ====
// Reference model for the crossing testbench: accepted control word,
// per-line pulse count and sticky pending bits.
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// worst-case req/ack round trip at the 40/56 ns clocks, with some slack
localparam int unsigned TRANSFER_NS = 700;

// A word counts as accepted only once it has been held for the
// required number of asic samples; shorter words leave the output alone.
function automatic logic [CTRL_W-1:0] next_ctrl_word(
  input logic [CTRL_W-1:0] current,
  input logic [CTRL_W-1:0] word,
  input int unsigned       samples
);
  if (samples >= STABLE_SAMPLES) begin
    return word;
  end
  return current;
endfunction

// pulses for a burst of rising edges on one line
function automatic int unsigned expected_pulse_count(
  input int unsigned n_edges,
  input int unsigned gap_ns,
  input bit          enabled
);
  if (!enabled || n_edges == 0) begin
    return 0;
  end
  if (gap_ns >= TRANSFER_NS) begin
    return n_edges;  // each edge finds the channel idle
  end
  // one in flight plus one queued, the rest merge
  return (n_edges > 2) ? 2 : n_edges;
endfunction

function automatic logic [N_EVENTS-1:0] expected_pending(
  input logic [N_EVENTS-1:0] current,
  input int unsigned         line,
  input int unsigned         new_pulses
);
  if (new_pulses > 0) begin
    return current | (N_EVENTS'(1) << line);
  end
  return current;
endfunction

`endif

// ==== verification/tb_efpga_cdc_bridge.sv ====
// Testbench for the ASIC/fabric crossing with clocks, reset, control word
// and event stimulus, a compare process, a watchdog and the summary.
`default_nettype none

module tb_efpga_cdc_bridge
  import efpga_ctrl_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned ASIC_PERIOD   = 40;
  localparam int unsigned FAB_PERIOD    = 56;
  localparam int unsigned DRIVE_DLY     = 5;
  localparam logic [31:0] SEED          = 32'h58ef1ad1;
  localparam int unsigned HOLD_CYC      = 6;   // asic cycles per stable word
  localparam int unsigned ACCEPT_FAB    = 6;   // fabric cycles allowed for acceptance
  localparam int unsigned N_WORDS       = 4;
  localparam int unsigned N_SINGLE      = 12;
  localparam int unsigned N_MASKED      = 4;
  localparam int unsigned EDGE_GAP_FAB  = 15;  // covers 20 asic cycles
  localparam int unsigned DOUBLE_WAIT   = 24;

  localparam int unsigned CTRL_NS   = (N_WORDS + 2) * (8 * FAB_PERIOD + 10 * ASIC_PERIOD);
  localparam int unsigned SINGLE_NS = N_SINGLE
                                      * ((EDGE_GAP_FAB + 2) * FAB_PERIOD + 2 * ASIC_PERIOD);
  localparam int unsigned MASKED_NS = (N_MASKED * (EDGE_GAP_FAB + 2) + 10) * FAB_PERIOD;
  localparam int unsigned DOUBLE_NS = (DOUBLE_WAIT + 6) * FAB_PERIOD + 8 * ASIC_PERIOD;
  localparam int unsigned STIM_NS   = 4 * ASIC_PERIOD + CTRL_NS + SINGLE_NS + MASKED_NS
                                      + DOUBLE_NS + 20 * ASIC_PERIOD;
  localparam int unsigned WATCHDOG_NS = STIM_NS + 200 * ASIC_PERIOD;

  logic                asic_clk_i;
  logic                efpga_clk_i;
  logic                rst_n;
  logic [CTRL_W-1:0]   ctrl_word_i;
  logic [CTRL_W-1:0]   ctrl_word_o;
  logic                event_en_i;
  logic [N_EVENTS-1:0] fab_event_i;
  logic [N_EVENTS-1:0] event_clr_i;
  logic [N_EVENTS-1:0] efpga_event_o;
  logic [N_EVENTS-1:0] event_pending_o;

  logic [CTRL_W-1:0]   exp_word;
  logic [N_EVENTS-1:0] exp_pending;
  int unsigned         exp_cnt [N_EVENTS];
  int unsigned         pulse_cnt [N_EVENTS];
  logic [CTRL_W-1:0]   glitch_word;
  bit                  glitch_watch;
  int unsigned         errors;
  int unsigned         checks;
  event                compare_ev;

  `include "tb_ref_model.svh"

  efpga_cdc_bridge dut0 (
    .asic_clk_i      (asic_clk_i),
    .efpga_clk_i     (efpga_clk_i),
    .rst_n           (rst_n),
    .ctrl_word_i     (ctrl_word_i),
    .ctrl_word_o     (ctrl_word_o),
    .event_en_i      (event_en_i),
    .fab_event_i     (fab_event_i),
    .event_clr_i     (event_clr_i),
    .efpga_event_o   (efpga_event_o),
    .event_pending_o (event_pending_o)
  );

  always #(ASIC_PERIOD / 2) asic_clk_i = ~asic_clk_i;
  always #(FAB_PERIOD / 2) efpga_clk_i = ~efpga_clk_i;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0d ns: %s expected 0x%0h actual 0x%0h",
               $time, name, expected, actual);
    end
  endtask

  // compare at a quiet point just after the drive delay
  task automatic request_compare();
    @(posedge asic_clk_i);
    #DRIVE_DLY;
    -> compare_ev;
    #1;  // compare process runs in this step
  endtask

  task automatic drive_stable_word(input logic [CTRL_W-1:0] word);
    int unsigned n;
    bit          seen;
    @(posedge asic_clk_i);
    #DRIVE_DLY;
    ctrl_word_i = word;
    exp_word = next_ctrl_word(exp_word, word, HOLD_CYC);
    n = 0;
    seen = 1'b0;
    while (!seen && n < ACCEPT_FAB) begin
      @(negedge efpga_clk_i);
      n++;
      if (ctrl_word_o === exp_word) begin
        seen = 1'b1;
      end
    end
    check_value("ctrl_word_o", exp_word, ctrl_word_o);
    repeat (HOLD_CYC) @(posedge asic_clk_i);
  endtask

  // held for a single asic sample until the next drive replaces it
  task automatic drive_glitch_word(input logic [CTRL_W-1:0] word);
    @(posedge asic_clk_i);
    #DRIVE_DLY;
    ctrl_word_i = word;
    glitch_word = word;
    glitch_watch = 1'b1;
    exp_word = next_ctrl_word(exp_word, word, 1);
  endtask

  task automatic raise_line(input int unsigned line, input int unsigned high_fab);
    @(posedge efpga_clk_i);
    #DRIVE_DLY;
    fab_event_i[line] = 1'b1;
    repeat (high_fab) @(posedge efpga_clk_i);
    #DRIVE_DLY;
    fab_event_i[line] = 1'b0;
  endtask

  task automatic set_enable(input logic en);
    @(posedge asic_clk_i);
    #DRIVE_DLY;
    event_en_i = en;
    repeat (4) @(posedge efpga_clk_i);  // through the enable synchronizer
  endtask

  // single spaced edges with the enable on or off
  task automatic spaced_edges(input int unsigned count, input bit enabled);
    int unsigned line;
    int unsigned added;
    for (int k = 0; k < count; k++) begin
      line = $urandom % N_EVENTS;
      raise_line(line, 2);
      repeat (EDGE_GAP_FAB - 2) @(posedge efpga_clk_i);
      added = expected_pulse_count(1, EDGE_GAP_FAB * FAB_PERIOD, enabled);
      exp_cnt[line] += added;
      exp_pending = expected_pending(exp_pending, line, added);
      request_compare();
    end
  endtask

  always @(negedge asic_clk_i) begin
    for (int i = 0; i < N_EVENTS; i++) begin
      if (efpga_event_o[i] === 1'b1) begin
        pulse_cnt[i]++;
      end
    end
  end

  always begin : compare_proc
    string cnt_name;
    @(compare_ev);
    check_value("ctrl_word_o", exp_word, ctrl_word_o);
    check_value("efpga_event_o", '0, efpga_event_o);
    check_value("event_pending_o", exp_pending, event_pending_o);
    for (int i = 0; i < N_EVENTS; i++) begin
      cnt_name = $sformatf("efpga_event_o[%0d] pulse count", i);
      check_value(cnt_name, exp_cnt[i], pulse_cnt[i]);
    end
  end

  always @(negedge efpga_clk_i) begin
    if (glitch_watch) begin
      check_value("ctrl_word_o took short word", 0, ctrl_word_o === glitch_word);
    end
  end

  initial begin : stimulus
    logic [CTRL_W-1:0] word;
    logic [CTRL_W-1:0] glitch;
    int unsigned       line;
    int unsigned       added;
    asic_clk_i   = 1'b0;
    efpga_clk_i  = 1'b0;
    rst_n        = 1'b0;
    ctrl_word_i  = '0;
    event_en_i   = 1'b0;
    fab_event_i  = '0;
    event_clr_i  = '0;
    exp_word     = '0;
    exp_pending  = '0;
    glitch_word  = '0;
    glitch_watch = 1'b0;
    errors       = 0;
    checks       = 0;
    for (int i = 0; i < N_EVENTS; i++) begin
      exp_cnt[i]   = 0;
      pulse_cnt[i] = 0;
    end
    void'($urandom(SEED));

    repeat (2) @(posedge asic_clk_i);
    #DRIVE_DLY;
    rst_n = 1'b1;
    request_compare();  // reset values

    for (int k = 0; k < N_WORDS; k++) begin
      word = $urandom;
      drive_stable_word(word);
    end
    glitch = ~exp_word;
    word = $urandom;
    if (word == glitch || word == exp_word) begin
      word = glitch ^ 32'h1;
    end
    drive_glitch_word(glitch);
    drive_stable_word(word);
    glitch_watch = 1'b0;
    request_compare();

    set_enable(1'b1);
    spaced_edges(N_SINGLE, 1'b1);

    set_enable(1'b0);
    spaced_edges(N_MASKED, 1'b0);
    set_enable(1'b1);

    // two edges two fabric cycles apart
    line = $urandom % N_EVENTS;
    raise_line(line, 1);
    raise_line(line, 1);
    repeat (DOUBLE_WAIT) @(posedge efpga_clk_i);
    added = expected_pulse_count(2, 2 * FAB_PERIOD, 1'b1);
    exp_cnt[line] += added;
    exp_pending = expected_pending(exp_pending, line, added);
    request_compare();

    @(posedge asic_clk_i);
    #DRIVE_DLY;
    event_clr_i = N_EVENTS'(1) << line;
    @(posedge asic_clk_i);
    #DRIVE_DLY;
    event_clr_i = '0;
    exp_pending = exp_pending & ~(N_EVENTS'(1) << line);
    request_compare();

    repeat (4) @(posedge asic_clk_i);
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: stimulus did not finish within %0d ns, %0d errors so far",
             WATCHDOG_NS, errors);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
